// ==== include/mc_defines.svh ====
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// ----------------------------------------------------------------------
// Memory system sizing
// ----------------------------------------------------------------------

// Column memory nodes, one per tile column
`define MC_NUM_COLUMNS 4

// Words held by each column memory
`define MC_COL_WORDS 16

`define MC_DATA_WIDTH 32

// Request tags cover the credit limit twice over
`define MC_TAG_WIDTH 3

`define MC_MAX_OUT_CREDITS 4

// Queue depth in each node and in the response merger
`define MC_FIFO_DEPTH 2

`endif

// ==== logic/mc_mem_pkg.sv ====
`include "mc_defines.svh"

package mc_mem_pkg;

   // Column select carried by a host request
   typedef logic [$clog2(`MC_NUM_COLUMNS)-1:0] col_id_t;

   // Word index inside one column memory
   typedef logic [$clog2(`MC_COL_WORDS)-1:0] word_addr_t;

   typedef logic [`MC_DATA_WIDTH-1:0] data_t;

   // Access kind
   typedef enum logic [0:0] {
      MEM_READ  = 1'b0,
      MEM_WRITE = 1'b1
   } mem_op_e;

endpackage

// ==== logic/mc_link_pkg.sv ====
`include "mc_defines.svh"

package mc_link_pkg;

   import mc_mem_pkg::*;

   typedef logic [`MC_TAG_WIDTH-1:0] tag_t;

   // ----------------------------------------------------------------------
   // Host side request
   // ----------------------------------------------------------------------
   typedef struct packed {
      mem_op_e    op;
      col_id_t    col;
      word_addr_t addr;
      data_t      data;
   } host_req_t;

   // ----------------------------------------------------------------------
   // Internal link packets
   // ----------------------------------------------------------------------

   // Column field is gone once the router has steered the request
   typedef struct packed {
      mem_op_e    op;
      word_addr_t addr;
      data_t      data;
      tag_t       tag;
   } link_req_t;

   // Data is the read word for a read, the written word for a write
   typedef struct packed {
      tag_t    tag;
      mem_op_e op;
      data_t   data;
   } link_rsp_t;

endpackage

// ==== logic/link_fifo.sv ====
`timescale 1ns/1ps

module link_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 2
) (
   input  logic     clk_main_a0,
   input  logic     rst_main_n_sync,
   input  logic     in_valid_i,
   input  payload_t in_data_i,
   output logic     in_ready_o,
   output logic     out_valid_o,
   output payload_t out_data_o,
   input  logic     out_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

   payload_t         mem_q [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   // Flags come straight from the occupancy count
   assign in_ready_o  = (count_q != FULL_CNT);
   assign out_valid_o = (count_q != '0);
   assign out_data_o  = mem_q[rd_ptr_q];

   assign push = in_valid_i && in_ready_o;
   assign pop  = out_valid_o && out_ready_i;

   always_ff @(posedge clk_main_a0) begin
      if (push) begin
         mem_q[wr_ptr_q] <= in_data_i;
      end
   end

   // Pointers wrap at DEPTH so any depth works, not only powers of two
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + PTR_W'(1);
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + CNT_W'(1);
            2'b01:   count_q <= count_q - CNT_W'(1);
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

// ==== logic/host_link_router.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module host_link_router
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
(
   input  logic                                  clk_main_a0,
   input  logic                                  rst_main_n_sync,
   input  logic                                  req_valid_i,
   input  host_req_t                             req_i,
   output logic                                  req_ready_o,
   output logic      [`MC_NUM_COLUMNS-1:0]       node_req_valid_o,
   output link_req_t [`MC_NUM_COLUMNS-1:0]       node_req_o,
   input  logic      [`MC_NUM_COLUMNS-1:0]       node_req_ready_i,
   input  logic                                  credit_return_i
);

   localparam int CNT_W = $clog2(`MC_MAX_OUT_CREDITS + 1);
   localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(`MC_MAX_OUT_CREDITS);

   logic [CNT_W-1:0] out_cnt_q;
   tag_t             tag_q;
   logic             credit_ok;
   logic             accept;

   // ----------------------------------------------------------------------
   // Flow control
   // ----------------------------------------------------------------------
   assign credit_ok   = (out_cnt_q < MAX_CNT);
   assign req_ready_o = credit_ok && node_req_ready_i[req_i.col];
   assign accept      = req_valid_i && req_ready_o;

   // ----------------------------------------------------------------------
   // Steering
   // ----------------------------------------------------------------------

   // Node valid does not look at node ready, so there is no loop back
   // through the node. A node transfer is exactly a host transfer.
   always_comb begin
      for (int i = 0; i < `MC_NUM_COLUMNS; i++) begin
         node_req_valid_o[i] = req_valid_i && credit_ok && (req_i.col == col_id_t'(i));
         node_req_o[i].op    = req_i.op;
         node_req_o[i].addr  = req_i.addr;
         node_req_o[i].data  = req_i.data;
         node_req_o[i].tag   = tag_q;
      end
   end

   // Outstanding count and tag sequence
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         out_cnt_q <= '0;
         tag_q     <= '0;
      end else begin
         case ({accept, credit_return_i})
            2'b10:   out_cnt_q <= out_cnt_q + CNT_W'(1);
            2'b01:   out_cnt_q <= out_cnt_q - CNT_W'(1);
            default: out_cnt_q <= out_cnt_q;
         endcase
         if (accept) begin
            tag_q <= tag_q + tag_t'(1);
         end
      end
   end

endmodule

// ==== logic/column_mem_node.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module column_mem_node
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
(
   input  logic      clk_main_a0,
   input  logic      rst_main_n_sync,
   input  logic      req_valid_i,
   input  link_req_t req_i,
   output logic      req_ready_o,
   output logic      rsp_valid_o,
   output link_rsp_t rsp_o,
   input  logic      rsp_ready_i
);

   data_t     mem_q [`MC_COL_WORDS];
   logic      head_valid;
   link_req_t head;
   logic      rsp_free;
   logic      serve;
   logic      rsp_valid_q;
   link_rsp_t rsp_q;

   // ----------------------------------------------------------------------
   // Request queue
   // ----------------------------------------------------------------------
   link_fifo #(
      .payload_t (link_req_t),
      .DEPTH     (`MC_FIFO_DEPTH)
   ) u_req_fifo (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .in_valid_i      (req_valid_i),
      .in_data_i       (req_i),
      .in_ready_o      (req_ready_o),
      .out_valid_o     (head_valid),
      .out_data_o      (head),
      .out_ready_i     (rsp_free)
   );

   // Response slot is free when empty or leaving this cycle
   assign rsp_free = !rsp_valid_q || rsp_ready_i;
   assign serve    = head_valid && rsp_free;

   // ----------------------------------------------------------------------
   // Word memory and response register
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_main_a0) begin
      if (serve) begin
         if (head.op == MEM_WRITE) begin
            mem_q[head.addr] <= head.data;
         end
         rsp_q.tag <= head.tag;
         rsp_q.op  <= head.op;
         // Writes echo their own data back
         rsp_q.data <= (head.op == MEM_WRITE) ? head.data : mem_q[head.addr];
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         rsp_valid_q <= 1'b0;
      end else if (serve) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
         rsp_valid_q <= 1'b0;
      end
   end

   assign rsp_valid_o = rsp_valid_q;
   assign rsp_o       = rsp_q;

endmodule

// ==== logic/rsp_merger.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module rsp_merger
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
(
   input  logic                            clk_main_a0,
   input  logic                            rst_main_n_sync,
   input  logic      [`MC_NUM_COLUMNS-1:0] col_rsp_valid_i,
   input  link_rsp_t [`MC_NUM_COLUMNS-1:0] col_rsp_i,
   output logic      [`MC_NUM_COLUMNS-1:0] col_rsp_ready_o,
   output logic                            rsp_valid_o,
   output link_rsp_t                       rsp_o,
   input  logic                            rsp_ready_i,
   output logic                            credit_return_o
);

   col_id_t last_q;
   col_id_t grant_idx;
   logic    grant_valid;
   logic    fifo_in_ready;

   // ----------------------------------------------------------------------
   // Round-robin pick starting just after the last winner
   // ----------------------------------------------------------------------
   always_comb begin
      col_id_t cand;
      grant_valid = 1'b0;
      grant_idx   = last_q;
      for (int k = 1; k <= `MC_NUM_COLUMNS; k++) begin
         cand = col_id_t'((int'(last_q) + k) % `MC_NUM_COLUMNS);
         if (!grant_valid && col_rsp_valid_i[cand]) begin
            grant_valid = 1'b1;
            grant_idx   = cand;
         end
      end
   end

   // Only the winner sees ready, and only if the queue has room
   always_comb begin
      for (int i = 0; i < `MC_NUM_COLUMNS; i++) begin
         col_rsp_ready_o[i] = grant_valid && fifo_in_ready && (grant_idx == col_id_t'(i));
      end
   end

   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         // Column 0 gets first pick after reset
         last_q <= col_id_t'(`MC_NUM_COLUMNS - 1);
      end else if (grant_valid && fifo_in_ready) begin
         last_q <= grant_idx;
      end
   end

   // ----------------------------------------------------------------------
   // Output queue towards the host
   // ----------------------------------------------------------------------
   link_fifo #(
      .payload_t (link_rsp_t),
      .DEPTH     (`MC_FIFO_DEPTH)
   ) u_rsp_fifo (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .in_valid_i      (grant_valid),
      .in_data_i       (col_rsp_i[grant_idx]),
      .in_ready_o      (fifo_in_ready),
      .out_valid_o     (rsp_valid_o),
      .out_data_o      (rsp_o),
      .out_ready_i     (rsp_ready_i)
   );

   // One credit back to the router per host response
   assign credit_return_o = rsp_valid_o && rsp_ready_i;

endmodule

// ==== logic/mc_mem_top.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_mem_top
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
(
   input  logic      clk_main_a0,
   input  logic      rst_main_n_sync,
   input  logic      req_valid_i,
   input  host_req_t req_i,
   output logic      req_ready_o,
   output logic      rsp_valid_o,
   output link_rsp_t rsp_o,
   input  logic      rsp_ready_i
);

   // Router to nodes
   logic      [`MC_NUM_COLUMNS-1:0] node_req_valid;
   link_req_t [`MC_NUM_COLUMNS-1:0] node_req;
   logic      [`MC_NUM_COLUMNS-1:0] node_req_ready;

   // Nodes to merger
   logic      [`MC_NUM_COLUMNS-1:0] col_rsp_valid;
   link_rsp_t [`MC_NUM_COLUMNS-1:0] col_rsp;
   logic      [`MC_NUM_COLUMNS-1:0] col_rsp_ready;

   logic credit_return;

   // ----------------------------------------------------------------------
   // Request side
   // ----------------------------------------------------------------------
   host_link_router u_router (
      .clk_main_a0      (clk_main_a0),
      .rst_main_n_sync  (rst_main_n_sync),
      .req_valid_i      (req_valid_i),
      .req_i            (req_i),
      .req_ready_o      (req_ready_o),
      .node_req_valid_o (node_req_valid),
      .node_req_o       (node_req),
      .node_req_ready_i (node_req_ready),
      .credit_return_i  (credit_return)
   );

   // One memory node per tile column
   for (genvar c = 0; c < `MC_NUM_COLUMNS; c++) begin : g_col
      column_mem_node u_node (
         .clk_main_a0     (clk_main_a0),
         .rst_main_n_sync (rst_main_n_sync),
         .req_valid_i     (node_req_valid[c]),
         .req_i           (node_req[c]),
         .req_ready_o     (node_req_ready[c]),
         .rsp_valid_o     (col_rsp_valid[c]),
         .rsp_o           (col_rsp[c]),
         .rsp_ready_i     (col_rsp_ready[c])
      );
   end

   // ----------------------------------------------------------------------
   // Response side
   // ----------------------------------------------------------------------
   rsp_merger u_merger (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .col_rsp_valid_i (col_rsp_valid),
      .col_rsp_i       (col_rsp),
      .col_rsp_ready_o (col_rsp_ready),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_o           (rsp_o),
      .rsp_ready_i     (rsp_ready_i),
      .credit_return_o (credit_return)
   );

endmodule

// ==== tests/mc_mem_props.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_mem_props
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
(
   input logic      clk_main_a0,
   input logic      rst_main_n_sync,
   input logic      req_valid_i,
   input logic      req_ready_i,
   input logic      rsp_valid_i,
   input link_rsp_t rsp_i,
   input logic      rsp_ready_i
);

   int violations = 0;
   int outstanding_q;

   // Accepted requests minus returned responses
   always_ff @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         outstanding_q <= 0;
      end else begin
         outstanding_q <= outstanding_q + int'(req_valid_i && req_ready_i)
                          - int'(rsp_valid_i && rsp_ready_i);
      end
   end

   // ----------------------------------------------------------------------
   // Credit limit
   // ----------------------------------------------------------------------
   a_credit_limit: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      outstanding_q >= 0 && outstanding_q <= `MC_MAX_OUT_CREDITS)
      else begin
         violations = violations + 1;
         $error("Outstanding request count out of range: %0d", outstanding_q);
      end

   // No credit left means no ready towards the host
   a_full_stalls: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      outstanding_q == `MC_MAX_OUT_CREDITS |-> !req_ready_i)
      else begin
         violations = violations + 1;
         $error("Request accepted with all credits in use");
      end

   // ----------------------------------------------------------------------
   // Response stream
   // ----------------------------------------------------------------------
   a_idle_quiet: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      outstanding_q == 0 |-> !rsp_valid_i)
      else begin
         violations = violations + 1;
         $error("Response valid with no request outstanding");
      end

   a_rsp_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_i))
      else begin
         violations = violations + 1;
         $error("Response dropped or changed while stalled");
      end

   a_reset_quiet: assert property (@(posedge clk_main_a0)
      !rst_main_n_sync |=> !rsp_valid_i)
      else begin
         violations = violations + 1;
         $error("Response valid right after reset");
      end

endmodule

// Checker rides along inside every memory top level
bind mc_mem_top mc_mem_props u_props (
   .clk_main_a0     (clk_main_a0),
   .rst_main_n_sync (rst_main_n_sync),
   .req_valid_i     (req_valid_i),
   .req_ready_i     (req_ready_o),
   .rsp_valid_i     (rsp_valid_o),
   .rsp_i           (rsp_o),
   .rsp_ready_i     (rsp_ready_i)
);

// ==== tests/mc_mem_tb.sv ====
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_mem_tb
   import mc_mem_pkg::*;
   import mc_link_pkg::*;
();

   localparam int NUM_TAGS = 1 << `MC_TAG_WIDTH;
   localparam int NUM_RAND = 300;
   localparam int NUM_REQ  = 24 + 6 + NUM_RAND;
   localparam int WDOG_CYC = NUM_REQ * 40 + 200;
   localparam int RDY_ON   = 0;
   localparam int RDY_OFF  = 1;
   localparam int RDY_RAND = 2;

   logic      clk_main_a0;
   logic      rst_main_n_sync;
   logic      req_valid_i;
   host_req_t req_i;
   logic      req_ready_o;
   logic      rsp_valid_o;
   link_rsp_t rsp_o;
   logic      rsp_ready_i;

   // Reference memory and table of outstanding tags
   data_t   ref_mem  [`MC_NUM_COLUMNS][`MC_COL_WORDS];
   logic    ref_set  [`MC_NUM_COLUMNS][`MC_COL_WORDS];
   logic    tag_busy [NUM_TAGS];
   mem_op_e exp_op   [NUM_TAGS];
   data_t   exp_data [NUM_TAGS];
   logic    exp_chk  [NUM_TAGS];
   tag_t    next_tag;
   int      outstanding;
   int      rsp_mode;

   mc_mem_top dut (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .req_valid_i     (req_valid_i),
      .req_i           (req_i),
      .req_ready_o     (req_ready_o),
      .rsp_valid_o     (rsp_valid_o),
      .rsp_o           (rsp_o),
      .rsp_ready_i     (rsp_ready_i)
   );

   initial begin
      clk_main_a0 = 1'b0;
      forever #2 clk_main_a0 = ~clk_main_a0;
   end

   // ----------------------------------------------------------------------
   // Failure reporting
   // ----------------------------------------------------------------------
   task automatic fail_now(input string what);
      $display("%s", what);
      $display("Test failures found");
      $fatal(1);
   endtask

   task automatic value_fail(input string name, input logic [31:0] got, input logic [31:0] exp);
      fail_now($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
   endtask

   // ----------------------------------------------------------------------
   // Reference model
   // ----------------------------------------------------------------------
   task automatic record_request(input host_req_t r);
      assert (!tag_busy[next_tag])
         else fail_now($sformatf("Tag %0d issued again while still outstanding", next_tag));
      tag_busy[next_tag] = 1'b1;
      exp_op[next_tag]   = r.op;
      if (r.op == MEM_WRITE) begin
         ref_mem[r.col][r.addr] = r.data;
         ref_set[r.col][r.addr] = 1'b1;
         exp_data[next_tag]     = r.data;
         exp_chk[next_tag]      = 1'b1;
      end else begin
         // Never-written words carry no expectation
         exp_data[next_tag] = ref_mem[r.col][r.addr];
         exp_chk[next_tag]  = ref_set[r.col][r.addr];
      end
      next_tag    = next_tag + tag_t'(1);
      outstanding = outstanding + 1;
   endtask

   task automatic check_response(input link_rsp_t r);
      assert (tag_busy[r.tag])
         else fail_now($sformatf("Response with tag %0d that is not outstanding", r.tag));
      assert (r.op == exp_op[r.tag])
         else value_fail("rsp_o.op", 32'(r.op), 32'(exp_op[r.tag]));
      if (exp_chk[r.tag]) begin
         assert (r.data == exp_data[r.tag])
            else value_fail("rsp_o.data", r.data, exp_data[r.tag]);
      end
      tag_busy[r.tag] = 1'b0;
      outstanding     = outstanding - 1;
   endtask

   // Transfers are taken from the values just before each rising edge
   always @(posedge clk_main_a0) begin
      if (!rst_main_n_sync) begin
         next_tag    = '0;
         outstanding = 0;
      end else begin
         if (rsp_valid_o && rsp_ready_i) begin
            check_response(rsp_o);
         end
         if (req_valid_i && req_ready_o) begin
            record_request(req_i);
         end
      end
   end

   // Host response ready
   always @(negedge clk_main_a0) begin
      case (rsp_mode)
         RDY_ON:  rsp_ready_i = 1'b1;
         RDY_OFF: rsp_ready_i = 1'b0;
         default: rsp_ready_i = ($urandom_range(3, 0) != 0);
      endcase
   end

   always @(negedge clk_main_a0) begin
      if (dut.u_props.violations != 0) begin
         fail_now("A protocol assertion on the DUT ports failed");
      end
   end

   initial begin
      repeat (WDOG_CYC) @(posedge clk_main_a0);
      fail_now($sformatf("Timeout after %0d cycles, %0d requests still outstanding",
                         WDOG_CYC, outstanding));
   end

   // ----------------------------------------------------------------------
   // Stimulus
   // ----------------------------------------------------------------------

   // Called at a falling edge, returns at the falling edge after the transfer
   task automatic send_req(input mem_op_e op, input col_id_t col, input word_addr_t addr,
                           input data_t data);
      req_valid_i = 1'b1;
      req_i.op    = op;
      req_i.col   = col;
      req_i.addr  = addr;
      req_i.data  = data;
      do @(posedge clk_main_a0); while (!req_ready_o);
      @(negedge clk_main_a0);
      req_valid_i = 1'b0;
   endtask

   task automatic wait_idle();
      do @(negedge clk_main_a0); while (outstanding != 0);
   endtask

   initial begin
      int dir_addr [3] = '{1, 6, 11};
      void'($urandom(31));
      rst_main_n_sync = 1'b0;
      req_valid_i     = 1'b0;
      req_i           = '0;
      rsp_ready_i     = 1'b1;
      rsp_mode        = RDY_ON;
      for (int t = 0; t < NUM_TAGS; t++) begin
         tag_busy[t] = 1'b0;
      end
      for (int c = 0; c < `MC_NUM_COLUMNS; c++) begin
         for (int a = 0; a < `MC_COL_WORDS; a++) begin
            ref_set[c][a] = 1'b0;
         end
      end
      repeat (2) @(posedge clk_main_a0);
      @(negedge clk_main_a0);
      rst_main_n_sync = 1'b1;

      // Directed writes followed by a read of each written word
      for (int c = 0; c < `MC_NUM_COLUMNS; c++) begin
         for (int k = 0; k < 3; k++) begin
            send_req(MEM_WRITE, col_id_t'(c), word_addr_t'(dir_addr[k]),
                     data_t'(32'hc0de_0000 | (c << 8) | dir_addr[k]));
         end
      end
      for (int c = 0; c < `MC_NUM_COLUMNS; c++) begin
         for (int k = 0; k < 3; k++) begin
            send_req(MEM_READ, col_id_t'(c), word_addr_t'(dir_addr[k]), '0);
         end
      end
      wait_idle();

      // Hold responses back until the credit limit stalls the host
      rsp_mode = RDY_OFF;
      fork
         for (int i = 0; i < 6; i++) begin
            send_req(MEM_WRITE, col_id_t'(i), word_addr_t'(i + 2), data_t'($urandom));
         end
         begin
            repeat (30) @(negedge clk_main_a0);
            assert (outstanding == `MC_MAX_OUT_CREDITS && !req_ready_o)
               else fail_now($sformatf("Credit stall expected at %0d requests, saw %0d",
                                       `MC_MAX_OUT_CREDITS, outstanding));
            rsp_mode = RDY_ON;
         end
      join
      wait_idle();

      // Random traffic with random response back-pressure
      rsp_mode = RDY_RAND;
      for (int i = 0; i < NUM_RAND; i++) begin
         send_req(($urandom_range(1, 0) == 1) ? MEM_WRITE : MEM_READ,
                  col_id_t'($urandom_range(`MC_NUM_COLUMNS - 1, 0)),
                  word_addr_t'($urandom_range(`MC_COL_WORDS - 1, 0)),
                  data_t'($urandom));
      end
      rsp_mode = RDY_ON;
      wait_idle();

      if (dut.u_props.violations == 0) begin
         $display("All tests passed!");
         $finish;
      end else begin
         fail_now("A protocol assertion on the DUT ports failed");
      end
   end

endmodule

// ==== all.f ====
+incdir+include
logic/mc_mem_pkg.sv
logic/mc_link_pkg.sv
logic/link_fifo.sv
logic/host_link_router.sv
logic/column_mem_node.sv
logic/rsp_merger.sv
logic/mc_mem_top.sv
tests/mc_mem_props.sv
tests/mc_mem_tb.sv

// ==== Makefile ====
TOOL     = verilator
TOP      = mc_mem_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir
PASS_MSG = All tests passed!

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The pipeline status is the status of grep, so a missing pass line fails
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
